// ==== common/link_test_pkg.sv ====
package link_test_pkg;

    //////////////////////////////
    // Lane counts
    //////////////////////////////

    // Transceiver lanes on the board
    localparam int NUM_LANES = 8;
    // Lanes 4 to 7 carry an error counter
    localparam int NUM_COUNTED_LANES = 4;
    localparam int FIRST_COUNTED_LANE = 4;

    // Front-panel LED count
    localparam int LED_WIDTH = 8;

    //////////////////////////////
    // CCB bus layout
    //////////////////////////////

    // Raw bus is active low
    localparam int CCB_WIDTH = 51;
    // Command field and its strobe
    localparam int CCB_CMD_LSB = 2;
    localparam int CCB_CMD_MSB = 7;
    localparam int CCB_STROBE_BIT = 10;

    // Decoded command codes
    typedef enum logic [5:0] {
        CMD_BX0    = 6'd1,
        CMD_RESYNC = 6'd3
    } ccb_opcode_t;

    //////////////////////////////
    // Boot timing
    //////////////////////////////

    // clk40 cycles per boot tick
    localparam int BOOT_TICK_DIV = 4;
    localparam int TICK_DIV_WIDTH = $clog2(BOOT_TICK_DIV);

    // Phase timer thresholds, in ticks
    localparam int TX_WAIT_TICKS = 20;
    localparam int RX_WAIT_TICKS = 40;
    localparam int INJECT_END_TICKS = 120;
    localparam int INJECT_DONE_TICKS = 140;
    localparam int CLEAR_END_TICKS = 160;
    // Wide enough for the last threshold
    localparam int TIMER_WIDTH = $clog2(CLEAR_END_TICKS + 1);

    // Per-lane saturating error counter
    localparam int ERR_COUNT_WIDTH = 2;
    localparam logic [ERR_COUNT_WIDTH-1:0] ERR_COUNT_MAX = '1;

    // Bring-up phases, value doubles as LED code
    typedef enum logic [3:0] {
        PH_RESET        = 4'd1,
        PH_EN_TX        = 4'd2,
        PH_TX_DONE      = 4'd3,
        PH_EN_RX        = 4'd4,
        PH_RX_DONE      = 4'd5,
        PH_INJECT       = 4'd6,
        PH_INJECT_DONE  = 4'd7,
        PH_INJECT_CLEAR = 4'd8,
        PH_CHECK        = 4'd10
    } boot_phase_t;

    // One-cycle command pulses from the CCB
    typedef struct packed {
        logic bx0;
        logic resync;
    } ccb_cmd_t;

    // PRBS control lines to the transceivers
    typedef struct packed {
        logic prbs_reset;
        logic counter_reset;
        logic error_inject;
    } prbs_ctrl_t;

endpackage

// ==== logic/ccb_decoder.sv ====
module ccb_decoder
    import link_test_pkg::*;
(
    input  logic                 clk40,
    input  logic                 reset,
    input  logic [CCB_WIDTH-1:0] ccb_rx_i,
    output ccb_cmd_t             cmd_o
);

    // Input stage of the raw bus
    logic [CCB_WIDTH-1:0] ccb_rx_q;
    // Active-high copy
    logic [CCB_WIDTH-1:0] ccb_rx;
    ccb_opcode_t          cmd_code;
    logic                 cmd_strobe;

    //////////////////////////////
    // Input register
    //////////////////////////////

    // Bus idles high, so reset loads all ones
    always_ff @(posedge clk40 or posedge reset) begin
        if (reset) begin
            ccb_rx_q <= '1;
        end else begin
            ccb_rx_q <= ccb_rx_i;
        end
    end

    // CCB lines are active low
    assign ccb_rx = ~ccb_rx_q;

    // Command field and strobe
    assign cmd_code   = ccb_opcode_t'(ccb_rx[CCB_CMD_MSB:CCB_CMD_LSB]);
    assign cmd_strobe = ccb_rx[CCB_STROBE_BIT];

    //////////////////////////////
    // Decode register
    //////////////////////////////

    // Pulse length follows the strobe
    always_ff @(posedge clk40 or posedge reset) begin
        if (reset) begin
            cmd_o <= '0;
        end else begin
            // Bunch crossing zero
            cmd_o.bx0    <= cmd_strobe && (cmd_code == CMD_BX0);
            // Resync of the optical links
            cmd_o.resync <= cmd_strobe && (cmd_code == CMD_RESYNC);
        end
    end

endmodule

// ==== boot/boot_sequencer.sv ====
module boot_sequencer
    import link_test_pkg::*;
(
    input  logic                 clk40,
    input  logic                 reset,
    input  ccb_cmd_t             cmd_i,
    input  logic [NUM_LANES-1:0] tx_done_i,
    input  logic [NUM_LANES-1:0] rx_done_i,
    input  logic                 inject_i,
    input  logic                 counter_reset_user_i,
    output boot_phase_t          phase_o,
    output logic [NUM_LANES-1:0] tx_reset_o,
    output logic [NUM_LANES-1:0] rx_reset_o,
    output prbs_ctrl_t           prbs_ctrl_o
);

    boot_phase_t               phase_q;
    boot_phase_t               phase_d;

    // Tick prescaler and phase timer
    logic [TICK_DIV_WIDTH-1:0] prescale_q;
    logic [TIMER_WIDTH-1:0]    timer_q;
    logic                      tick;
    logic                      timer_clear;

    // All lanes report reset done
    logic                      tx_all_done;
    logic                      rx_all_done;

    assign tx_all_done = &tx_done_i;
    assign rx_all_done = &rx_done_i;

    //////////////////////////////
    // Tick prescaler and timer
    //////////////////////////////

    // Timer restarts in the reset and wait-for-done phases
    assign timer_clear = (phase_q == PH_RESET) ||
                         (phase_q == PH_TX_DONE) ||
                         (phase_q == PH_RX_DONE);

    // One tick every BOOT_TICK_DIV cycles
    assign tick = (prescale_q == TICK_DIV_WIDTH'(BOOT_TICK_DIV - 1));

    always_ff @(posedge clk40 or posedge reset) begin
        if (reset) begin
            prescale_q <= '0;
            timer_q    <= '0;
        end else if (timer_clear) begin
            prescale_q <= '0;
            timer_q    <= '0;
        end else begin
            if (tick) begin
                prescale_q <= '0;
            end else begin
                prescale_q <= prescale_q + 1'b1;
            end
            // Hold at full scale while idling in check
            if (tick && (timer_q != '1)) begin
                timer_q <= timer_q + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Phase FSM
    //////////////////////////////

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            PH_RESET: begin
                phase_d = PH_EN_TX;
            end
            // Give TX reset release time to settle
            PH_EN_TX: begin
                if (timer_q >= TIMER_WIDTH'(TX_WAIT_TICKS)) begin
                    phase_d = PH_TX_DONE;
                end
            end
            // Unbounded wait on the transmitters
            PH_TX_DONE: begin
                if (tx_all_done) begin
                    phase_d = PH_EN_RX;
                end
            end
            PH_EN_RX: begin
                if (timer_q >= TIMER_WIDTH'(RX_WAIT_TICKS)) begin
                    phase_d = PH_RX_DONE;
                end
            end
            // Unbounded wait on the receivers
            PH_RX_DONE: begin
                if (rx_all_done) begin
                    phase_d = PH_INJECT;
                end
            end
            // Injection window, timer keeps running across these three
            PH_INJECT: begin
                if (timer_q >= TIMER_WIDTH'(INJECT_END_TICKS)) begin
                    phase_d = PH_INJECT_DONE;
                end
            end
            PH_INJECT_DONE: begin
                if (timer_q >= TIMER_WIDTH'(INJECT_DONE_TICKS)) begin
                    phase_d = PH_INJECT_CLEAR;
                end
            end
            PH_INJECT_CLEAR: begin
                if (timer_q >= TIMER_WIDTH'(CLEAR_END_TICKS)) begin
                    phase_d = PH_CHECK;
                end
            end
            // Free-running check, left only by resync
            PH_CHECK: begin
                phase_d = PH_CHECK;
            end
            default: begin
                phase_d = PH_RESET;
            end
        endcase
        // Resync restarts bring-up from any phase
        if (cmd_i.resync) begin
            phase_d = PH_RESET;
        end
    end

    always_ff @(posedge clk40 or posedge reset) begin
        if (reset) begin
            phase_q <= PH_RESET;
        end else begin
            phase_q <= phase_d;
        end
    end

    assign phase_o = phase_q;

    //////////////////////////////
    // Output decode
    //////////////////////////////

    always_comb begin
        // Safe state, everything held in reset
        tx_reset_o                = '1;
        rx_reset_o                = '1;
        prbs_ctrl_o.prbs_reset    = 1'b1;
        prbs_ctrl_o.counter_reset = 1'b1;
        prbs_ctrl_o.error_inject  = 1'b0;
        case (phase_q)
            PH_EN_TX, PH_TX_DONE: begin
                tx_reset_o = '0;
            end
            PH_EN_RX: begin
                tx_reset_o = '0;
                rx_reset_o = '0;
            end
            // PRBS checkers come out of reset
            PH_RX_DONE, PH_INJECT_CLEAR: begin
                tx_reset_o                = '0;
                rx_reset_o                = '0;
                prbs_ctrl_o.prbs_reset    = 1'b0;
                prbs_ctrl_o.counter_reset = 1'b0;
            end
            PH_INJECT: begin
                tx_reset_o                = '0;
                rx_reset_o                = '0;
                prbs_ctrl_o.prbs_reset    = 1'b0;
                prbs_ctrl_o.counter_reset = 1'b0;
                prbs_ctrl_o.error_inject  = 1'b1;
            end
            // Still injecting, but counters held clear
            PH_INJECT_DONE: begin
                tx_reset_o               = '0;
                rx_reset_o               = '0;
                prbs_ctrl_o.error_inject = 1'b1;
            end
            // User and BX0 control injection from here on
            PH_CHECK: begin
                tx_reset_o                = '0;
                rx_reset_o                = '0;
                prbs_ctrl_o.prbs_reset    = 1'b0;
                prbs_ctrl_o.counter_reset = counter_reset_user_i;
                prbs_ctrl_o.error_inject  = inject_i | cmd_i.bx0;
            end
            default: begin
                tx_reset_o = '1;
                rx_reset_o = '1;
            end
        endcase
    end

endmodule

// ==== display/error_display.sv ====
module error_display
    import link_test_pkg::*;
(
    input  logic                         clk40,
    input  logic                         reset,
    input  boot_phase_t                  phase_i,
    input  logic                         counter_reset_i,
    input  logic [NUM_COUNTED_LANES-1:0] prbs_error_i,
    output logic [LED_WIDTH-1:0]         led_o
);

    // Index 0 is lane FIRST_COUNTED_LANE
    logic [ERR_COUNT_WIDTH-1:0]   err_cnt_q [NUM_COUNTED_LANES];

    // Counter MSBs, lane 4 in the top bit
    logic [NUM_COUNTED_LANES-1:0] cnt_msb;
    // Full counts, lane 4 in the top pair
    logic [LED_WIDTH-1:0]         cnt_pairs;

    //////////////////////////////
    // Saturating error counters
    //////////////////////////////

    always_ff @(posedge clk40 or posedge reset) begin
        if (reset) begin
            for (int lane = 0; lane < NUM_COUNTED_LANES; lane++) begin
                err_cnt_q[lane] <= '0;
            end
        end else begin
            for (int lane = 0; lane < NUM_COUNTED_LANES; lane++) begin
                if (counter_reset_i) begin
                    err_cnt_q[lane] <= '0;
                end else if (prbs_error_i[lane] && (err_cnt_q[lane] != ERR_COUNT_MAX)) begin
                    // One count per error cycle, stops at full scale
                    err_cnt_q[lane] <= err_cnt_q[lane] + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // LED multiplexer
    //////////////////////////////

    // Reorder so the first counted lane lands on the left
    always_comb begin
        cnt_msb   = '0;
        cnt_pairs = '0;
        for (int lane = 0; lane < NUM_COUNTED_LANES; lane++) begin
            cnt_msb[NUM_COUNTED_LANES-1-lane] = err_cnt_q[lane][ERR_COUNT_WIDTH-1];
            cnt_pairs[LED_WIDTH-1-lane*ERR_COUNT_WIDTH -: ERR_COUNT_WIDTH] = err_cnt_q[lane];
        end
    end

    always_comb begin
        case (phase_i)
            // Bring-up shows only the phase code
            PH_RESET, PH_EN_TX, PH_TX_DONE, PH_EN_RX, PH_RX_DONE: begin
                led_o = {phase_i, {NUM_COUNTED_LANES{1'b0}}};
            end
            // Injection shows whether each lane has seen errors
            PH_INJECT, PH_INJECT_DONE, PH_INJECT_CLEAR: begin
                led_o = {phase_i, cnt_msb};
            end
            // Check phase gives the whole panel to the counts
            PH_CHECK: begin
                led_o = cnt_pairs;
            end
            default: begin
                led_o = '0;
            end
        endcase
    end

endmodule

// ==== logic/link_test_top.sv ====
module link_test_top
    import link_test_pkg::*;
(
    input  logic                 clk40,
    input  logic                 reset,
    // Raw CCB bus, active low
    input  logic [CCB_WIDTH-1:0] ccb_rx_i,
    // Transceiver status
    input  logic [NUM_LANES-1:0] tx_reset_done_i,
    input  logic [NUM_LANES-1:0] rx_reset_done_i,
    input  logic [NUM_LANES-1:0] prbs_error_i,
    // Front-panel user controls
    input  logic                 inject_i,
    input  logic                 counter_reset_user_i,
    // Transceiver control
    output logic [NUM_LANES-1:0] tx_reset_o,
    output logic [NUM_LANES-1:0] rx_reset_o,
    output prbs_ctrl_t           prbs_ctrl_o,
    output logic [LED_WIDTH-1:0] led_o
);

    ccb_cmd_t    ccb_cmd;
    boot_phase_t phase;

    //////////////////////////////
    // CCB command decode
    //////////////////////////////

    ccb_decoder u_ccb_decoder (
        .clk40    (clk40),
        .reset    (reset),
        .ccb_rx_i (ccb_rx_i),
        .cmd_o    (ccb_cmd)
    );

    // Bring-up FSM
    boot_sequencer u_boot_sequencer (
        .clk40                (clk40),
        .reset                (reset),
        .cmd_i                (ccb_cmd),
        .tx_done_i            (tx_reset_done_i),
        .rx_done_i            (rx_reset_done_i),
        .inject_i             (inject_i),
        .counter_reset_user_i (counter_reset_user_i),
        .phase_o              (phase),
        .tx_reset_o           (tx_reset_o),
        .rx_reset_o           (rx_reset_o),
        .prbs_ctrl_o          (prbs_ctrl_o)
    );

    // Only the upper four lanes are counted
    error_display u_error_display (
        .clk40           (clk40),
        .reset           (reset),
        .phase_i         (phase),
        .counter_reset_i (prbs_ctrl_o.counter_reset),
        .prbs_error_i    (prbs_error_i[FIRST_COUNTED_LANE +: NUM_COUNTED_LANES]),
        .led_o           (led_o)
    );

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk40,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 2;

    // 8 ns period
    initial begin
        clk40 = 1'b0;
        forever begin
            #4 clk40 = ~clk40;
        end
    end

    // Released just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk40);
        #1;
        reset = 1'b0;
    end

endmodule

// ==== test/link_test_properties.sv ====
module link_test_properties
    import link_test_pkg::*;
(
    input logic                 clk40,
    input logic                 reset,
    input boot_phase_t          phase_i,
    input logic [NUM_LANES-1:0] tx_reset_i,
    input logic [NUM_LANES-1:0] rx_reset_i,
    input prbs_ctrl_t           prbs_ctrl_i,
    input logic                 counter_reset_user_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Next phase in the bring-up order
    function automatic boot_phase_t successor(input boot_phase_t from);
        case (from)
            PH_RESET:        return PH_EN_TX;
            PH_EN_TX:        return PH_TX_DONE;
            PH_TX_DONE:      return PH_EN_RX;
            PH_EN_RX:        return PH_RX_DONE;
            PH_RX_DONE:      return PH_INJECT;
            PH_INJECT:       return PH_INJECT_DONE;
            PH_INJECT_DONE:  return PH_INJECT_CLEAR;
            PH_INJECT_CLEAR: return PH_CHECK;
            default:         return PH_RESET;
        endcase
    endfunction

    //////////////////////////////
    // Sequencer rules
    //////////////////////////////

    // Receivers leave reset a cycle after every transmitter already has
    rx_after_tx: assert property (
        @(posedge clk40) disable iff (reset)
        ((rx_reset_i != '1) && ($past(rx_reset_i) == '1)) |-> ($past(tx_reset_i) == '0)
    ) else $error("rx_reset released before tx_reset was released");

    // Forward one step, or back to the start on resync
    phase_order: assert property (
        @(posedge clk40) disable iff (reset)
        (phase_i != $past(phase_i)) |->
            ((phase_i == PH_RESET) || (phase_i == successor($past(phase_i))))
    ) else $error("illegal phase change to %0d", phase_i);

    // User counter clear only matters in the check phase
    inject_vs_clear: assert property (
        @(posedge clk40) disable iff (reset)
        (counter_reset_user_i && (phase_i != PH_CHECK)) |-> !prbs_ctrl_i.error_inject
    ) else $error("error_inject set during user counter clear outside check");

endmodule

bind boot_sequencer link_test_properties u_sequencer_props (
    .clk40                (clk40),
    .reset                (reset),
    .phase_i              (phase_q),
    .tx_reset_i           (tx_reset_o),
    .rx_reset_i           (rx_reset_o),
    .prbs_ctrl_i          (prbs_ctrl_o),
    .counter_reset_user_i (counter_reset_user_i)
);

// ==== test/link_test_tb.sv ====
module link_test_tb
    import link_test_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_ROWS = 16;
    localparam int RESET_TIMEOUT = 10;
    localparam int BRINGUP_TIMEOUT = 4000;
    localparam int MIN_INJECT_CYCLES = (INJECT_DONE_TICKS - RX_WAIT_TICKS) * BOOT_TICK_DIV;

    logic                 clk40;
    logic                 reset;
    // CCB idles high
    logic [CCB_WIDTH-1:0] ccb_rx = '1;
    logic [NUM_LANES-1:0] tx_done = '0;
    logic [NUM_LANES-1:0] rx_done = '0;
    logic [NUM_LANES-1:0] prbs_error = '0;
    logic                 inject = 1'b0;
    logic                 counter_reset_user = 1'b0;
    logic [NUM_LANES-1:0] tx_reset;
    logic [NUM_LANES-1:0] rx_reset;
    prbs_ctrl_t           prbs_ctrl;
    logic [LED_WIDTH-1:0] led;

    // Row is cmd[39:32] pulses[31:16] led[15:8] ctrl[7:4] user clear[3:0]
    logic [39:0]          pattern_mem [MAX_ROWS];
    int                   tx_wait [NUM_LANES];
    int                   rx_wait [NUM_LANES];
    int                   seed = 32'hd26e;
    int                   error_count = 0;
    int                   check_count = 0;
    logic                 abort_run = 1'b0;

    tb_clock_gen u_clock_gen (
        .clk40 (clk40),
        .reset (reset)
    );

    link_test_top uut (
        .clk40                (clk40),
        .reset                (reset),
        .ccb_rx_i             (ccb_rx),
        .tx_reset_done_i      (tx_done),
        .rx_reset_done_i      (rx_done),
        .prbs_error_i         (prbs_error),
        .inject_i             (inject),
        .counter_reset_user_i (counter_reset_user),
        .tx_reset_o           (tx_reset),
        .rx_reset_o           (rx_reset),
        .prbs_ctrl_o          (prbs_ctrl),
        .led_o                (led)
    );

    //////////////////////////////
    // Transceiver model
    //////////////////////////////

    // Done rises 1 to 16 cycles after the lane's reset drops
    always @(posedge clk40) begin
        #1;
        for (int lane = 0; lane < NUM_LANES; lane++) begin
            if (tx_reset[lane]) begin
                tx_done[lane] = 1'b0;
                tx_wait[lane] = 1 + ({$random(seed)} % 16);
            end else if (tx_wait[lane] > 0) begin
                tx_wait[lane]--;
            end else begin
                tx_done[lane] = 1'b1;
            end
            if (rx_reset[lane]) begin
                rx_done[lane] = 1'b0;
                rx_wait[lane] = 1 + ({$random(seed)} % 16);
            end else if (rx_wait[lane] > 0) begin
                rx_wait[lane]--;
            end else begin
                rx_done[lane] = 1'b1;
            end
        end
    end

    // Drive point just after the next rising edge
    task automatic step();
        @(posedge clk40);
        #1;
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0d ns: %s is 0x%02h, expected 0x%02h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    //////////////////////////////
    // Bring-up walk
    //////////////////////////////

    // Entered at a falling edge while the DUT sits in its reset phase
    task automatic bring_up();
        int         cycles;
        int         inject_cycles;
        logic [3:0] last_code;
        logic       in_check;
        check_value("tx_reset_o", tx_reset, 8'hFF);
        check_value("rx_reset_o", rx_reset, 8'hFF);
        check_value("prbs_ctrl_o", 8'(prbs_ctrl), 8'h06);
        check_value("led_o upper nibble", 8'(led[7:4]), 8'h01);
        cycles = 0;
        inject_cycles = 0;
        last_code = 4'd1;
        in_check = 1'b0;
        while (!in_check && cycles < BRINGUP_TIMEOUT) begin
            @(negedge clk40);
            cycles++;
            if (prbs_ctrl.error_inject) begin
                inject_cycles++;
            end
            if (rx_reset != '1 && tx_reset != '0) begin
                report_error("rx_reset_o released while tx_reset_o still set");
            end
            if (rx_reset != '1 && tx_done != '1) begin
                report_error("rx_reset_o released before all TX done flags were set");
            end
            // Counts cleared during injection, so the check phase shows all zero
            if (last_code == 4'd8 && led == '0) begin
                in_check = 1'b1;
            end else if (led[7:4] != last_code) begin
                if (led[7:4] != last_code + 4'd1) begin
                    report_error($sformatf("LED phase code went from %0d to %0d",
                                           last_code, led[7:4]));
                end
                last_code = led[7:4];
            end
        end
        if (!in_check) begin
            report_error("timeout, check phase not reached during bring-up");
            abort_run = 1'b1;
        end else if (inject_cycles < MIN_INJECT_CYCLES) begin
            report_error($sformatf("error_inject high for only %0d cycles", inject_cycles));
        end
    endtask

    //////////////////////////////
    // Pattern rows
    //////////////////////////////

    task automatic run_row(input logic [39:0] row);
        logic [5:0]           code;
        logic [CCB_WIDTH-1:0] cmd_bits;
        step();
        code = row[37:32];
        counter_reset_user = row[0];
        // Lane 4 count in the top nibble of the pulse field
        for (int i = 0; i < 15; i++) begin
            for (int lane = 0; lane < NUM_COUNTED_LANES; lane++) begin
                prbs_error[FIRST_COUNTED_LANE + lane] = (i < int'(row[31 - 4*lane -: 4]));
            end
            step();
        end
        prbs_error = '0;
        step();
        if (code != '0) begin
            cmd_bits = '0;
            cmd_bits[CCB_CMD_MSB:CCB_CMD_LSB] = code;
            cmd_bits[CCB_STROBE_BIT] = 1'b1;
            ccb_rx = ~cmd_bits;
            step();
            // Single-cycle strobe
            ccb_rx = '1;
            @(negedge clk40);
            check_value("error_inject one cycle after CCB", 8'(prbs_ctrl.error_inject), 8'h00);
            @(posedge clk40);
            // Resync shows one cycle later, through the phase register
            if (code == CMD_RESYNC) begin
                @(posedge clk40);
            end
        end
        @(negedge clk40);
        check_value("led_o", led, row[15:8]);
        check_value("prbs_ctrl_o", 8'(prbs_ctrl), 8'(row[7:4]));
        if (code == CMD_RESYNC) begin
            bring_up();
        end
    endtask

    task automatic end_run();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    initial begin
        int cycles;
        int row_idx;
        $readmemh("test/link_test_patterns.txt", pattern_mem);
        cycles = 0;
        @(negedge clk40);
        while (reset && cycles < RESET_TIMEOUT) begin
            @(negedge clk40);
            cycles++;
        end
        if (reset) begin
            report_error("reset was never released");
            abort_run = 1'b1;
        end else begin
            bring_up();
        end
        row_idx = 0;
        while (!abort_run && row_idx < MAX_ROWS && pattern_mem[row_idx][39:32] != 8'hFF) begin
            run_row(pattern_mem[row_idx]);
            row_idx++;
        end
        end_run();
    end

endmodule

// ==== test/link_test_patterns.txt ====
// cmd_pulses_led_ctrl_user: cmd 00 none, 01 BX0, 03 RESYNC, FF ends the list
// pulses lanes 4..7, expected led_o, expected {prbs_reset,counter_reset,error_inject}, user clear
00_1230_6C_0_0
00_2105_FF_0_0
00_0000_00_2_1
00_3333_00_2_1
00_0014_07_0_0
01_0000_07_1_0
03_0000_10_6_0
00_3021_C9_0_0
FF_0000_00_0_0

// ==== list.f ====
common/link_test_pkg.sv
logic/ccb_decoder.sv
boot/boot_sequencer.sv
display/error_display.sv
logic/link_test_top.sv
test/tb_clock_gen.sv
test/link_test_properties.sv
test/link_test_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = link_test_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
